// ==== ghash_defs.svh ====
`ifndef GHASH_DEFS_SVH
`define GHASH_DEFS_SVH

// Width of one GF(2^128) element and of one data block
`define NB_BLOCK 128

// Blocks absorbed per input beat
// The datapath has been sized for 1 to 4 lanes
`define N_BLOCKS 2

// Top byte of the GCM reduction constant
// x^0 + x^1 + x^2 + x^7 in the reflected bit order
`define GF_R_MSBYTE 8'he1

`endif

// ==== gf_pkg.sv ====
`include "ghash_defs.svh"

package gf_pkg;

    // One field element in GCM order
    // Bit NB_BLOCK-1 holds the x^0 coefficient and bit 0 holds x^127
    typedef logic [`NB_BLOCK-1:0] gf_elem_t;

    // Reduction constant R of the GCM specification
    // 11100001 followed by zeros down to bit 0
    localparam gf_elem_t GF_R = {
        `GF_R_MSBYTE,
        {(`NB_BLOCK - 8){1'b0}}
    };

    // Multiply an element by x
    // A right shift in GCM order, with R folded in when x^127 falls off
    function automatic gf_elem_t gf_mul_x(input gf_elem_t i_v);
        gf_elem_t shifted;
        shifted = i_v >> 1;
        if (i_v[0])
        begin
            shifted = shifted ^ GF_R;
        end
        return shifted;
    endfunction

endpackage

// ==== ghash_pkg.sv ====
`include "ghash_defs.svh"

package ghash_pkg;

    // Operation of one lane in the chain
    typedef enum logic
    {
        LANE_ABSORB = 1'b0, // XOR block in, then multiply by H
        LANE_SKIP   = 1'b1  // Pass accumulator through
    } lane_op_e;

    // One input beat
    // blocks[0] is processed first and sits at the low end of the bus
    typedef struct packed
    {
        gf_pkg::gf_elem_t [`N_BLOCKS-1:0] blocks;
        logic [`N_BLOCKS-1:0]             skip;  // One bit per lane
        logic                             sop;   // Reload from initial value
        logic                             valid;
    } ghash_beat_t;

    // Lane opcode from its skip bit
    function automatic lane_op_e lane_op_from_skip(input logic i_skip);
        lane_op_e op;
        op = LANE_ABSORB;
        if (i_skip)
        begin
            op = LANE_SKIP;
        end
        return op;
    endfunction

endpackage

// ==== gf128_multiplier.sv ====
`include "ghash_defs.svh"

module gf128_multiplier
(
    input  gf_pkg::gf_elem_t i_a,
    input  gf_pkg::gf_elem_t i_b,
    output gf_pkg::gf_elem_t o_product
);

    import gf_pkg::*;

    localparam int unsigned NB = `NB_BLOCK;

    // z_stage[i] is the partial product after i bits of i_a
    // v_stage[i] is i_b times x^i, already reduced
    gf_elem_t z_stage [0:NB];
    gf_elem_t v_stage [0:NB-1];

    assign z_stage[0] = '0;
    assign v_stage[0] = i_b;

    genvar i;
    generate
        for (i = 0; i < NB; i++)
        begin : g_bit
            // Bit NB-1 of i_a is the x^0 coefficient, walk toward x^127
            logic a_bit;

            assign a_bit = i_a[NB-1-i];

            always_comb
            begin
                if (a_bit)
                begin
                    z_stage[i+1] = z_stage[i] ^ v_stage[i];
                end
                else
                begin
                    z_stage[i+1] = z_stage[i];
                end
            end

            // The last shifted copy would never be added
            if (i < NB - 1)
            begin : g_shift
                assign v_stage[i+1] = gf_mul_x(v_stage[i]);
            end
        end
    endgenerate

    assign o_product = z_stage[NB];

endmodule

// ==== ghash_lane.sv ====
module ghash_lane
(
    input  gf_pkg::gf_elem_t    i_acc,
    input  gf_pkg::gf_elem_t    i_block,
    input  ghash_pkg::lane_op_e i_op,
    input  gf_pkg::gf_elem_t    i_hash_subkey_h,
    output gf_pkg::gf_elem_t    o_acc
);

    import gf_pkg::*;
    import ghash_pkg::*;

    gf_elem_t sum;
    gf_elem_t product;

    assign sum = i_acc ^ i_block; // Absorb the block

    gf128_multiplier u_mult
    (
        .i_a       (sum),
        .i_b       (i_hash_subkey_h),
        .o_product (product)
    );

    // A skipped lane leaves the chain untouched
    always_comb
    begin
        unique case (i_op)
            LANE_ABSORB:
            begin
                o_acc = product;
            end
            LANE_SKIP:
            begin
                o_acc = i_acc;
            end
            default:
            begin
                o_acc = i_acc;
            end
        endcase
    end

endmodule

// ==== ghash_n_blocks.sv ====
`include "ghash_defs.svh"

module ghash_n_blocks
(
    input  logic                   i_clock,
    input  logic                   i_arst_n,
    input  ghash_pkg::ghash_beat_t i_beat,
    input  gf_pkg::gf_elem_t       i_data_x_initial,
    input  gf_pkg::gf_elem_t       i_hash_subkey_h,
    output gf_pkg::gf_elem_t       o_data_y,
    output logic                   o_valid
);

    import gf_pkg::*;
    import ghash_pkg::*;

    localparam int unsigned N = `N_BLOCKS;

    gf_elem_t hash_q;           // Running hash
    logic     valid_q;
    gf_elem_t seed;
    gf_elem_t chain [0:N];      // chain[k] feeds lane k
    lane_op_e lane_op [0:N-1];

    // New packet restarts from the caller's initial value
    always_comb
    begin
        if (i_beat.sop)
        begin
            seed = i_data_x_initial;
        end
        else
        begin
            seed = hash_q;
        end
    end

    assign chain[0] = seed;

    genvar k;
    generate
        for (k = 0; k < N; k++)
        begin : g_lane
            assign lane_op[k] = lane_op_from_skip(i_beat.skip[k]);

            ghash_lane u_lane
            (
                .i_acc           (chain[k]),
                .i_block         (i_beat.blocks[k]),
                .i_op            (lane_op[k]),
                .i_hash_subkey_h (i_hash_subkey_h),
                .o_acc           (chain[k+1])
            );
        end
    endgenerate

    // Whole chain settles within one clock
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            hash_q  <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= i_beat.valid; // One strobe per beat
            if (i_beat.valid)
            begin
                hash_q <= chain[N];
            end
        end
    end

    assign o_data_y = hash_q;
    assign o_valid  = valid_q;

    // Start of packet only comes with a valid beat
    a_sop_needs_valid : assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        i_beat.sop |-> i_beat.valid
    ) else $error("ghash_n_blocks: sop without valid");

    // Payload and control fields are clean on a valid beat
    a_beat_known : assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        i_beat.valid |-> !$isunknown({i_beat.blocks, i_beat.skip, i_beat.sop})
    ) else $error("ghash_n_blocks: unknown bits on a valid beat");

endmodule

// ==== tb_ghash_n_blocks.sv ====
`include "ghash_defs.svh"

module tb_ghash_n_blocks;

    timeunit 1ns;
    timeprecision 1ps;

    import gf_pkg::*;
    import ghash_pkg::*;

    localparam int N_LANES      = `N_BLOCKS;
    localparam int RESET_CYCLES = 4;
    localparam int N_RANDOM     = 48;

    typedef gf_elem_t [N_LANES-1:0] blocks_t;

    // One stimulus row, with an optional known answer
    typedef struct packed
    {
        blocks_t              blocks;
        logic [N_LANES-1:0]   skip;
        logic                 sop;
        logic                 valid;
        gf_elem_t             init;
        gf_elem_t             h;
        logic                 has_exp;
        gf_elem_t             exp;
    } row_t;

    logic        clock;
    logic        arst_n;
    ghash_beat_t beat;
    gf_elem_t    data_x_initial;
    gf_elem_t    hash_subkey_h;
    gf_elem_t    data_y;
    logic        valid_out;

    row_t     rows [$];
    integer   seed = 61250;
    int       value_errors;
    int       strobe_errors;
    bit       table_ready;
    gf_elem_t model_hash;     // Software accumulator
    logic     exp_valid;
    gf_elem_t exp_y;
    logic     exp_known;
    gf_elem_t exp_ref;

    ghash_n_blocks u_dut
    (
        .i_clock          (clock),
        .i_arst_n         (arst_n),
        .i_beat           (beat),
        .i_data_x_initial (data_x_initial),
        .i_hash_subkey_h  (hash_subkey_h),
        .o_data_y         (data_y),
        .o_valid          (valid_out)
    );

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Bitwise multiply from the GCM specification
    function automatic gf_elem_t gf_multiply(input gf_elem_t a, input gf_elem_t b);
        gf_elem_t z;
        gf_elem_t v;
        z = '0;
        v = b;
        for (int i = 0; i < `NB_BLOCK; i++)
        begin
            if (a[`NB_BLOCK-1-i])
            begin
                z = z ^ v;
            end
            if (v[0])
            begin
                v = (v >> 1) ^ GF_R;
            end
            else
            begin
                v = v >> 1;
            end
        end
        return z;
    endfunction

    function automatic gf_elem_t rand_elem();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic blocks_t rand_blocks();
        blocks_t b;
        for (int k = 0; k < N_LANES; k++)
        begin
            b[k] = rand_elem();
        end
        return b;
    endfunction

    task automatic push_row(input blocks_t blocks, input logic [N_LANES-1:0] skip,
                            input logic sop, input logic valid, input gf_elem_t init,
                            input gf_elem_t h, input logic has_exp, input gf_elem_t exp);
        row_t r;
        r.blocks  = blocks;
        r.skip    = skip;
        r.sop     = sop;
        r.valid   = valid;
        r.init    = init;
        r.h       = h;
        r.has_exp = has_exp;
        r.exp     = exp;
        rows.push_back(r);
    endtask

    task automatic build_table();
        blocks_t            b;
        logic [N_LANES-1:0] sk;
        gf_elem_t           kat_h;
        gf_elem_t           init;
        gf_elem_t           h;
        logic               v;
        logic               s;
        kat_h = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
        b     = '0;
        sk    = '1;
        for (int k = 0; k < N_LANES && k < 2; k++)
        begin
            b[k]  = (k == 0) ? 128'h0388dace60b6a392f328c2b971b2fe78 : 128'h80; // C, then lengths
            sk[k] = 1'b0;
        end
        push_row(b, sk, 1'b1, 1'b1, '0, kat_h, N_LANES >= 2,
                 128'hf38cbb1ad69223dcc3457ae5b6b0f885);
        repeat (3) push_row(rand_blocks(), '0, 1'b0, 1'b1, '0, kat_h, 1'b0, '0);
        repeat (2) push_row(rand_blocks(), '0, 1'b0, 1'b0, '0, kat_h, 1'b0, '0); // Idle
        init = 128'h0123456789abcdeffedcba9876543210;
        h    = rand_elem();
        push_row(rand_blocks(), '0, 1'b1, 1'b1, init, h, 1'b0, '0);
        push_row(rand_blocks(), '0, 1'b0, 1'b1, init, h, 1'b0, '0);
        for (int p = 0; p < (1 << N_LANES); p++)
        begin
            push_row(rand_blocks(), N_LANES'(p), 1'b0, 1'b1, '0, h, 1'b0, '0);
        end
        push_row(rand_blocks(), '1, 1'b1, 1'b1, init, h, 1'b1, init); // Seed passes through
        push_row(rand_blocks(), '0, 1'b0, 1'b0, '0, h, 1'b0, '0);
        for (int n = 0; n < N_RANDOM; n++)
        begin
            v  = ($random(seed) & 3) != 0;
            s  = v && (($random(seed) & 3) == 0);
            sk = N_LANES'($random(seed));
            push_row(rand_blocks(), sk, s, v, rand_elem(), rand_elem(), 1'b0, '0);
        end
    endtask

    task automatic model_beat(input row_t r);
        gf_elem_t acc;
        exp_valid = r.valid;
        exp_known = r.has_exp;
        exp_ref   = r.exp;
        if (r.valid)
        begin
            acc = r.sop ? r.init : model_hash;
            for (int k = 0; k < N_LANES; k++)
            begin
                if (!r.skip[k])
                begin
                    acc = gf_multiply(acc ^ r.blocks[k], r.h);
                end
            end
            model_hash = acc;
        end
        exp_y = model_hash; // Idle keeps the old hash
    endtask

    task automatic drive_row(input row_t r);
        beat.blocks    = r.blocks;
        beat.skip      = r.skip;
        beat.sop       = r.sop;
        beat.valid     = r.valid;
        data_x_initial = r.init;
        hash_subkey_h  = r.h;
    endtask

    task automatic check_result(input int idx);
        if (valid_out !== exp_valid)
        begin
            strobe_errors++;
            if (exp_valid)
            begin
                $display("Missing o_valid strobe after row %0d", idx);
            end
            else
            begin
                $display("Unexpected o_valid strobe after row %0d", idx);
            end
        end
        if (data_y !== exp_y)
        begin
            value_errors++;
            $display("Error o_data_y expected %h got %h (row %0d)", exp_y, data_y, idx);
        end
        if (exp_known && data_y !== exp_ref)
        begin
            value_errors++;
            $display("Error o_data_y known answer %h got %h (row %0d)", exp_ref, data_y, idx);
        end
    endtask

    initial
    begin
        wait (table_ready);
        #((rows.size() + RESET_CYCLES + 20) * 8);
        $display("Timeout: the test did not finish in the expected time");
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        arst_n         = 1'b0;
        beat           = '0;
        data_x_initial = '0;
        hash_subkey_h  = '0;
        value_errors   = 0;
        strobe_errors  = 0;
        model_hash     = '0;
        exp_valid      = 1'b0;
        exp_y          = '0;
        exp_known      = 1'b0;
        exp_ref        = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        arst_n = 1'b1;
        if (valid_out !== 1'b0)
        begin
            strobe_errors++;
            $display("o_valid is not low right after reset");
        end
        if (data_y !== 128'h0)
        begin
            value_errors++;
            $display("Error o_data_y expected %h got %h (after reset)", 128'h0, data_y);
        end
        for (int i = 0; i < rows.size(); i++)
        begin
            @(posedge clock);
            #1;
            check_result(i - 1); // Row -1 is the idle cycle after reset
            model_beat(rows[i]);
            drive_row(rows[i]);
        end
        @(posedge clock);
        #1;
        check_result(rows.size() - 1);
        model_beat('0);
        beat = '0;
        @(posedge clock);
        #1;
        check_result(rows.size());
        $display("Summary: %0d value errors, %0d strobe errors", value_errors, strobe_errors);
        if (value_errors + strobe_errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
gf_pkg.sv
ghash_pkg.sv
gf128_multiplier.sv
ghash_lane.sv
ghash_n_blocks.sv
tb_ghash_n_blocks.sv
